// File: source/emu_pkg.sv
package emu_pkg;

    // Scan word and datapath sizes.
    localparam int scan_width     = 64;
    localparam int data_width     = 32;
    localparam int ram_addr_width = 8;
    localparam int ram_depth      = 1 << ram_addr_width;
    localparam int ff_chain_words = 2;

    // Instruction field layout.
    localparam int opcode_width = 4;
    localparam int opcode_lsb   = 28;   // Opcode in bits 31..28.
    localparam int imm_width    = 16;   // Zero-extended immediate.
    localparam int addr_field   = 0;    // Lsb of the memory address.

    // Word 0 of the flip-flop chain: acc, pc, halted, then zero padding.
    localparam int ff_acc_lsb    = scan_width - data_width;
    localparam int ff_pc_lsb     = ff_acc_lsb - ram_addr_width;
    localparam int ff_halted_bit = ff_pc_lsb - 1;
    localparam int ff_pad_width  = ff_halted_bit;

    typedef enum logic [opcode_width-1:0] {
        op_nop   = 4'd0,
        op_ldi   = 4'd1,
        op_addi  = 4'd2,
        op_subi  = 4'd3,
        op_addm  = 4'd4,
        op_store = 4'd5,
        op_jnz   = 4'd6,
        op_halt  = 4'd7
    } emu_opcode_e;

    typedef enum logic [1:0] {
        mode_stop = 2'd0,
        mode_run  = 2'd1,
        mode_scan = 2'd2
    } emu_mode_e;

endpackage

// File: source/emu_ram_model.sv
`timescale 1ns/1ps

module emu_ram_model (
    input  logic                                host_clk,
    input  logic                                reset,

    // Target side.
    input  logic [emu_pkg::ram_addr_width-1:0]  fetch_addr,
    output logic [emu_pkg::data_width-1:0]      fetch_data,
    input  logic [emu_pkg::ram_addr_width-1:0]  data_addr,
    input  logic                                data_write,
    input  logic [emu_pkg::data_width-1:0]      data_wdata,
    output logic [emu_pkg::data_width-1:0]      data_rdata,

    // Scan side.
    input  logic                                scan_reset,
    input  logic                                scan_step,
    input  logic                                scan_write,
    input  logic [emu_pkg::data_width-1:0]      scan_wdata,
    output logic [emu_pkg::scan_width-1:0]      scan_rdata
);

    logic [emu_pkg::data_width-1:0]     mem [emu_pkg::ram_depth];
    logic [emu_pkg::ram_addr_width-1:0] scan_addr;
    logic                               scan_go;

    assign scan_go = scan_step && !scan_reset;  // Counter reset wins.

    assign fetch_data = mem[fetch_addr];
    assign data_rdata = mem[data_addr];

    always_ff @(posedge host_clk) begin
        if (data_write) begin
            mem[data_addr] <= data_wdata;
        end else if (scan_go && scan_write) begin
            mem[scan_addr] <= scan_wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        if (reset) begin
            scan_addr <= '0;
        end else if (scan_reset) begin
            scan_addr <= '0;
        end else if (scan_go) begin
            scan_addr <= scan_addr + 1'b1;  // Wraps at the top.
        end
    end

    // Dump word holds until the next read step.
    always_ff @(posedge host_clk) begin
        if (reset) begin
            scan_rdata <= '0;
        end else if (scan_go && !scan_write) begin
            scan_rdata <= {{(emu_pkg::scan_width - emu_pkg::data_width){1'b0}},
                           mem[scan_addr]};
        end
    end

endmodule

// File: source/emu_target.sv
`timescale 1ns/1ps

module emu_target (
    input  logic                                host_clk,
    input  logic                                reset,
    input  logic                                tick,
    input  logic                                ff_shift,
    input  logic [emu_pkg::scan_width-1:0]      ff_di,
    input  logic [emu_pkg::data_width-1:0]      insn,
    input  logic [emu_pkg::data_width-1:0]      mem_rdata,
    output logic [emu_pkg::ram_addr_width-1:0]  pc,
    output logic [emu_pkg::ram_addr_width-1:0]  mem_addr,
    output logic                                mem_write,
    output logic [emu_pkg::data_width-1:0]      mem_wdata,
    output logic                                halted,
    output logic [emu_pkg::scan_width-1:0]      ff_do
);

    logic [emu_pkg::data_width-1:0]     acc;
    logic [emu_pkg::data_width-1:0]     insn_count;
    logic [emu_pkg::data_width-1:0]     store_count;

    logic [emu_pkg::data_width-1:0]     acc_next;
    logic [emu_pkg::ram_addr_width-1:0] pc_next;
    logic                               halted_next;
    logic [emu_pkg::data_width-1:0]     store_count_next;

    emu_pkg::emu_opcode_e               opcode;
    logic [emu_pkg::data_width-1:0]     imm;
    logic [emu_pkg::ram_addr_width-1:0] addr;

    logic [emu_pkg::ff_chain_words-1:0][emu_pkg::scan_width-1:0] chain;

    // Decode.
    assign opcode = emu_pkg::emu_opcode_e'(insn[emu_pkg::opcode_lsb +: emu_pkg::opcode_width]);
    assign imm    = {{(emu_pkg::data_width - emu_pkg::imm_width){1'b0}},
                     insn[emu_pkg::imm_width-1:0]};
    assign addr   = insn[emu_pkg::addr_field +: emu_pkg::ram_addr_width];

    assign mem_addr  = addr;
    assign mem_wdata = acc;
    assign mem_write = tick && (opcode == emu_pkg::op_store);

    always_comb begin
        acc_next         = acc;
        pc_next          = pc + 1'b1;
        halted_next      = halted;
        store_count_next = store_count;
        case (opcode)
            emu_pkg::op_nop: begin
                acc_next = acc;
            end
            emu_pkg::op_ldi: begin
                acc_next = imm;
            end
            emu_pkg::op_addi: begin
                acc_next = acc + imm;
            end
            emu_pkg::op_subi: begin
                acc_next = acc - imm;
            end
            emu_pkg::op_addm: begin
                acc_next = acc + mem_rdata;
            end
            emu_pkg::op_store: begin
                store_count_next = store_count + 1'b1;
            end
            emu_pkg::op_jnz: begin
                if (acc != '0) begin
                    pc_next = addr;
                end
            end
            default: begin
                halted_next = 1'b1;     // Halt and unknown codes.
                pc_next     = pc;
            end
        endcase
    end

    // Scan chain view of the state.
    assign chain[0] = {acc, pc, halted, {emu_pkg::ff_pad_width{1'b0}}};
    assign chain[1] = {insn_count, store_count};
    assign ff_do    = chain[emu_pkg::ff_chain_words-1];

    always_ff @(posedge host_clk) begin
        if (reset) begin
            acc         <= '0;
            pc          <= '0;
            halted      <= 1'b0;
            insn_count  <= '0;
            store_count <= '0;
        end else if (ff_shift) begin
            // Word 1 takes word 0, word 0 takes the chain input.
            insn_count  <= chain[0][emu_pkg::scan_width-1 -: emu_pkg::data_width];
            store_count <= chain[0][emu_pkg::data_width-1:0];
            acc         <= ff_di[emu_pkg::scan_width-1:emu_pkg::ff_acc_lsb];
            pc          <= ff_di[emu_pkg::ff_pc_lsb +: emu_pkg::ram_addr_width];
            halted      <= ff_di[emu_pkg::ff_halted_bit];
        end else if (tick) begin
            acc         <= acc_next;
            pc          <= pc_next;
            halted      <= halted_next;
            insn_count  <= insn_count + 1'b1;
            store_count <= store_count_next;
        end
    end

endmodule

// File: source/emu_system.sv
`timescale 1ns/1ps

module emu_system (
    input  logic                            host_clk,
    input  logic                            reset,
    input  logic                            run_mode,
    input  logic                            scan_mode,
    input  logic                            ff_scan,
    input  logic [emu_pkg::scan_width-1:0]  ff_di,
    output logic [emu_pkg::scan_width-1:0]  ff_do,
    input  logic                            ram_scan_reset,
    input  logic                            ram_scan,
    input  logic                            ram_dir,
    input  logic [emu_pkg::scan_width-1:0]  ram_sdi,
    output logic [emu_pkg::scan_width-1:0]  ram_sdo,
    output logic                            idle,
    output logic                            target_tick
);

    emu_pkg::emu_mode_e                 mode;
    logic                               in_scan;
    logic                               tick;
    logic                               ff_shift;
    logic                               scan_reset;
    logic                               scan_step;
    logic                               scan_write;

    logic [emu_pkg::ram_addr_width-1:0] pc;
    logic [emu_pkg::ram_addr_width-1:0] mem_addr;
    logic                               mem_write;
    logic [emu_pkg::data_width-1:0]     mem_wdata;
    logic [emu_pkg::data_width-1:0]     mem_rdata;
    logic [emu_pkg::data_width-1:0]     insn;
    logic                               halted;

    // Scan has priority over run.
    always_ff @(posedge host_clk) begin
        if (reset) begin
            mode <= emu_pkg::mode_stop;
        end else if (scan_mode) begin
            mode <= emu_pkg::mode_scan;
        end else if (run_mode) begin
            mode <= emu_pkg::mode_run;
        end else begin
            mode <= emu_pkg::mode_stop;
        end
    end

    assign in_scan     = (mode == emu_pkg::mode_scan);
    assign tick        = (mode == emu_pkg::mode_run) && !halted;
    assign ff_shift    = ff_scan && in_scan;
    assign scan_reset  = ram_scan_reset && in_scan;
    assign scan_step   = ram_scan && in_scan;
    assign scan_write  = ram_dir && in_scan;
    assign idle        = !tick;
    assign target_tick = tick;

    emu_target u_target (
        .host_clk   (host_clk),
        .reset      (reset),
        .tick       (tick),
        .ff_shift   (ff_shift),
        .ff_di      (ff_di),
        .insn       (insn),
        .mem_rdata  (mem_rdata),
        .pc         (pc),
        .mem_addr   (mem_addr),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .halted     (halted),
        .ff_do      (ff_do)
    );

    emu_ram_model u_ram (
        .host_clk   (host_clk),
        .reset      (reset),
        .fetch_addr (pc),
        .fetch_data (insn),
        .data_addr  (mem_addr),
        .data_write (mem_write),
        .data_wdata (mem_wdata),
        .data_rdata (mem_rdata),
        .scan_reset (scan_reset),
        .scan_step  (scan_step),
        .scan_write (scan_write),
        .scan_wdata (ram_sdi[emu_pkg::data_width-1:0]),     // Low word only.
        .scan_rdata (ram_sdo)
    );

endmodule

// File: source/emu_top.sv
`timescale 1ns/1ps

module emu_top (
    input  logic                            host_clk,
    input  logic                            reset,

    input  logic                            run_mode,
    input  logic                            scan_mode,
    output logic                            idle,
    output logic                            target_tick,

    input  logic                            ff_scan,
    input  logic                            ff_dir,
    input  logic [emu_pkg::scan_width-1:0]  ff_sdi,
    output logic [emu_pkg::scan_width-1:0]  ff_sdo,

    input  logic                            ram_scan_reset,
    input  logic                            ram_scan,
    input  logic                            ram_dir,
    input  logic [emu_pkg::scan_width-1:0]  ram_sdi,
    output logic [emu_pkg::scan_width-1:0]  ram_sdo
);

    logic [emu_pkg::scan_width-1:0] ff_chain_in;

    // External shift-in or circular rotation.
    assign ff_chain_in = ff_dir ? ff_sdi : ff_sdo;

    emu_system u_system (
        .host_clk       (host_clk),
        .reset          (reset),
        .run_mode       (run_mode),
        .scan_mode      (scan_mode),
        .ff_scan        (ff_scan),
        .ff_di          (ff_chain_in),
        .ff_do          (ff_sdo),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .ram_sdo        (ram_sdo),
        .idle           (idle),
        .target_tick    (target_tick)
    );

endmodule

// File: dv/emu_top_sva.sv
`timescale 1ns/1ps

module emu_top_sva (
    input logic                            host_clk,
    input logic                            reset,
    input logic                            run_mode,
    input logic                            scan_mode,
    input logic                            ram_scan_reset,
    input logic                            ram_scan,
    input logic                            ram_dir,
    input logic [emu_pkg::scan_width-1:0]  ram_sdo,
    input logic                            idle,
    input logic                            target_tick
);

    logic scan_read;

    assign scan_read = ram_scan && !ram_dir && !ram_scan_reset;

    // A tick needs a run request taken by the mode register.
    idle_is_not_tick: assert property (@(posedge host_clk) disable iff (reset)
        (idle == !target_tick) && (!target_tick || $past(run_mode)))
        else $error("idle is not the inverse of target_tick, or a tick without run_mode");

    // Mode register follows scan_mode one cycle later.
    no_tick_after_scan: assert property (@(posedge host_clk) disable iff (reset)
        $past(scan_mode) |-> !target_tick)
        else $error("target_tick high in the cycle after scan_mode");

    sdo_holds: assert property (@(posedge host_clk) disable iff (reset)
        !($past(scan_read) && $past(scan_mode, 2)) |-> $stable(ram_sdo))
        else $error("ram_sdo changed without a scan read step");

endmodule

bind emu_top emu_top_sva u_sva (
    .host_clk       (host_clk),
    .reset          (reset),
    .run_mode       (run_mode),
    .scan_mode      (scan_mode),
    .ram_scan_reset (ram_scan_reset),
    .ram_scan       (ram_scan),
    .ram_dir        (ram_dir),
    .ram_sdo        (ram_sdo),
    .idle           (idle),
    .target_tick    (target_tick)
);

// File: dv/emu_tb.sv
`timescale 1ns/1ps

module emu_tb;

    localparam int timeout_cycles = 4000;

    logic        host_clk = 1'b0;
    logic        reset;
    logic        run_mode;
    logic        scan_mode;
    logic        ff_scan;
    logic        ff_dir;
    logic [63:0] ff_sdi;
    logic [63:0] ff_sdo;
    logic        ram_scan_reset;
    logic        ram_scan;
    logic        ram_dir;
    logic [63:0] ram_sdi;
    logic [63:0] ram_sdo;
    logic        idle;
    logic        target_tick;

    // Reference machine state and its memory.
    logic [31:0] mirror [emu_pkg::ram_depth];
    logic [31:0] m_acc;
    logic [7:0]  m_pc;
    logic        m_halted;
    logic [31:0] m_insn;
    logic [31:0] m_store;

    int error_count = 0;
    int check_count = 0;
    int tick_count = 0;
    int prog_len;

    emu_top dut (
        .host_clk       (host_clk),
        .reset          (reset),
        .run_mode       (run_mode),
        .scan_mode      (scan_mode),
        .idle           (idle),
        .target_tick    (target_tick),
        .ff_scan        (ff_scan),
        .ff_dir         (ff_dir),
        .ff_sdi         (ff_sdi),
        .ff_sdo         (ff_sdo),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .ram_sdo        (ram_sdo)
    );

    always #2 host_clk = ~host_clk;

    always @(posedge host_clk) begin
        if (target_tick) begin
            tick_count <= tick_count + 1;
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors: %0d, checks: %0d", error_count + 1, check_count);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic apply_reset();
        @(posedge host_clk);
        reset <= 1'b1;
        repeat (3) @(posedge host_clk);
        reset <= 1'b0;
        m_acc    = '0;
        m_pc     = '0;
        m_halted = 1'b0;
        m_insn   = '0;
        m_store  = '0;
    endtask

    task automatic set_mode(input logic run, input logic scan);
        @(posedge host_clk);
        run_mode  <= run;
        scan_mode <= scan;
        @(posedge host_clk);    // Mode register loads here.
    endtask

    task automatic ram_load();
        @(posedge host_clk);
        ram_scan_reset <= 1'b1;
        @(posedge host_clk);
        ram_scan_reset <= 1'b0;
        ram_scan       <= 1'b1;
        ram_dir        <= 1'b1;
        for (int i = 0; i < emu_pkg::ram_depth; i++) begin
            ram_sdi <= {$urandom, mirror[i]};   // Upper word is ignored.
            @(posedge host_clk);
        end
        ram_scan <= 1'b0;
        ram_dir  <= 1'b0;
    endtask

    task automatic ram_dump(input string name);
        logic [63:0] held;
        @(posedge host_clk);
        ram_scan_reset <= 1'b1;
        for (int i = 0; i < emu_pkg::ram_depth; i++) begin
            @(posedge host_clk);
            ram_scan_reset <= 1'b0;
            ram_scan       <= 1'b1;
            @(posedge host_clk);
            ram_scan <= 1'b0;
            @(negedge host_clk);
            held = ram_sdo;
            check({name, " dump"}, {32'h0, mirror[i]}, ram_sdo);
            @(posedge host_clk);
            @(negedge host_clk);
            check({name, " dump hold"}, held, ram_sdo);
        end
    endtask

    // Two circular shifts read both words and restore the chain.
    task automatic ff_rotate_out(output logic [63:0] w0, output logic [63:0] w1);
        @(negedge host_clk);
        w1 = ff_sdo;
        @(posedge host_clk);
        ff_dir  <= 1'b0;
        ff_scan <= 1'b1;
        @(posedge host_clk);
        @(negedge host_clk);
        w0 = ff_sdo;
        @(posedge host_clk);
        ff_scan <= 1'b0;
    endtask

    task automatic ff_shift_in(input logic [63:0] w0, input logic [63:0] w1);
        @(posedge host_clk);
        ff_dir  <= 1'b1;
        ff_scan <= 1'b1;
        ff_sdi  <= w1;
        @(posedge host_clk);
        ff_sdi <= w0;
        @(posedge host_clk);
        ff_scan <= 1'b0;
        ff_dir  <= 1'b0;
    endtask

    task automatic check_state(input string name);
        logic [63:0] w0;
        logic [63:0] w1;
        ff_rotate_out(w0, w1);
        check({name, " word0"}, {m_acc, m_pc, m_halted, 23'h0}, w0);
        check({name, " word1"}, {m_insn, m_store}, w1);
        m_store[22:0] = '0;     // Word 0 has no room for these bits of store_count.
    endtask

    task automatic model_run();
        logic [31:0] insn;
        logic [31:0] imm;
        logic [7:0]  addr;
        logic [7:0]  next_pc;
        int          steps;
        steps = 0;
        while (!m_halted && steps < timeout_cycles) begin
            insn    = mirror[m_pc];
            imm     = {16'h0, insn[15:0]};
            addr    = insn[7:0];
            next_pc = m_pc + 8'd1;
            m_insn  = m_insn + 1;
            steps++;
            case (insn[31:28])
                emu_pkg::op_nop:   ;
                emu_pkg::op_ldi:   m_acc = imm;
                emu_pkg::op_addi:  m_acc = m_acc + imm;
                emu_pkg::op_subi:  m_acc = m_acc - imm;
                emu_pkg::op_addm:  m_acc = m_acc + mirror[addr];
                emu_pkg::op_store: begin
                    mirror[addr] = m_acc;
                    m_store      = m_store + 1;
                end
                emu_pkg::op_jnz: begin
                    if (m_acc != 0) begin
                        next_pc = addr;
                    end
                end
                default: begin
                    m_halted = 1'b1;
                    next_pc  = m_pc;
                end
            endcase
            m_pc = next_pc;
        end
    endtask

    task automatic run_until_idle(input string name);
        int cycles;
        cycles = 0;
        @(posedge host_clk);
        run_mode  <= 1'b1;
        scan_mode <= 1'b0;
        @(posedge host_clk);
        @(negedge host_clk);
        while (!(idle && dut.u_system.halted) && cycles < timeout_cycles) begin
            @(negedge host_clk);
            cycles++;
        end
        if (cycles >= timeout_cycles) begin
            abort_run({"Timeout: ", name, " never reached a halted idle state"});
        end else begin
            @(posedge host_clk);
            run_mode <= 1'b0;
        end
    endtask

    task automatic run_and_compare(input string name, input int ticks_start);
        logic [31:0] insn_start;
        insn_start = m_insn;
        model_run();
        run_until_idle(name);
        set_mode(1'b0, 1'b1);
        check({name, " ticks"}, m_insn - insn_start, tick_count - ticks_start);
        check_state(name);
        ram_dump(name);
    endtask

    // Straight-line code at the bottom, data accesses in the upper half.
    task automatic make_program();
        logic [3:0] op;
        for (int i = 0; i < emu_pkg::ram_depth; i++) begin
            mirror[i] = $urandom;
        end
        prog_len = $urandom_range(8, 48);
        for (int i = 0; i < prog_len - 1; i++) begin
            op = 4'($urandom_range(0, 5));
            if (op == emu_pkg::op_addm || op == emu_pkg::op_store) begin
                mirror[i] = {op, 20'h0, 1'b1, 7'($urandom)};
            end else begin
                mirror[i] = {op, 12'h0, 16'($urandom)};
            end
        end
        mirror[prog_len - 1] = {emu_pkg::op_halt, 28'h0};
    endtask

    task automatic run_program(input string name, input bit interrupt);
        logic [63:0] w0;
        logic [63:0] w1;
        int          ticks_start;
        apply_reset();
        set_mode(1'b0, 1'b1);
        ram_load();
        ticks_start = tick_count;
        if (interrupt) begin
            @(posedge host_clk);
            run_mode  <= 1'b1;
            scan_mode <= 1'b1;
            repeat ($urandom_range(4, 20)) @(posedge host_clk);
            @(negedge host_clk);
            check({name, " priority ticks"}, ticks_start, tick_count);
            ff_rotate_out(w0, w1);
            check({name, " priority counts"}, 64'h0, w1);
            @(posedge host_clk);
            scan_mode <= 1'b0;
            repeat ($urandom_range(3, prog_len)) @(posedge host_clk);
            run_mode <= 1'b0;   // Stop mid-program, then resume.
            repeat (4) @(posedge host_clk);
        end
        run_and_compare(name, ticks_start);
    endtask

    initial begin
        reset          = 1'b1;
        run_mode       = 1'b0;
        scan_mode      = 1'b0;
        ff_scan        = 1'b0;
        ff_dir         = 1'b0;
        ff_sdi         = '0;
        ram_scan_reset = 1'b0;
        ram_scan       = 1'b0;
        ram_dir        = 1'b0;
        ram_sdi        = '0;
        void'($urandom(32'h5c924a75));

        apply_reset();
        @(negedge host_clk);
        check("reset idle", 64'h1, idle);
        check("reset tick", 64'h0, target_tick);
        check("reset ram_sdo", 64'h0, ram_sdo);
        set_mode(1'b0, 1'b1);
        check_state("reset state");

        for (int i = 0; i < emu_pkg::ram_depth; i++) begin
            mirror[i] = $urandom;
        end
        ram_load();
        ram_dump("ram scan");

        for (int n = 0; n < 6; n++) begin
            make_program();
            run_program("random program", 1'b0);
        end

        check_state("ff rotate first");
        check_state("ff rotate second");
        m_acc    = $urandom;
        m_pc     = 8'($urandom_range(0, prog_len - 1));
        m_halted = 1'b0;
        m_insn   = $urandom;
        m_store  = $urandom;
        ff_shift_in({m_acc, m_pc, 1'b0, 23'($urandom)}, {m_insn, m_store});
        m_store[22:0] = '0;     // Word 1 passed through word 0 on the way in.
        check_state("ff shift in");
        run_and_compare("ff resume", tick_count);

        make_program();
        run_program("mode priority", 1'b1);

        // Countdown that stores every value of acc.
        for (int i = 0; i < emu_pkg::ram_depth; i++) begin
            mirror[i] = $urandom;
        end
        mirror[0] = {emu_pkg::op_ldi, 12'h0, 16'($urandom_range(3, 30))};
        mirror[1] = {emu_pkg::op_store, 20'h0, 8'd200};
        mirror[2] = {emu_pkg::op_subi, 12'h0, 16'd1};
        mirror[3] = {emu_pkg::op_jnz, 20'h0, 8'd1};
        mirror[4] = {emu_pkg::op_halt, 28'h0};
        prog_len  = 5;
        run_program("countdown", 1'b0);

        $display("Errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: emu.f
source/emu_pkg.sv
source/emu_ram_model.sv
source/emu_target.sv
source/emu_system.sv
source/emu_top.sv
dv/emu_top_sva.sv
dv/emu_tb.sv

// File: Bender.yml
package:
  name: emu

sources:
  - files:
      - source/emu_pkg.sv
      - source/emu_ram_model.sv
      - source/emu_target.sv
      - source/emu_system.sv
      - source/emu_top.sv
  - target: test
    files:
      - dv/emu_top_sva.sv
      - dv/emu_tb.sv
